// File: bus_pkg.sv
package bus_pkg;

  // Data word
  localparam int XLEN = 32;

  // APB address
  localparam int ADDR_W = 32;

  // One strobe per byte lane
  localparam int STRB_W = XLEN / 8;

  // Cycle limit for a single APB transfer
  localparam int APB_TIMEOUT = 64;

endpackage

// File: exu_pkg.sv
package exu_pkg;

  // Which unit executes the instruction
  typedef enum logic [1:0] {
    UNIT_ALU    = 2'd0,
    UNIT_MULDIV = 2'd1,
    UNIT_LOAD   = 2'd2,
    UNIT_STORE  = 2'd3
  } unit_t;

  // ALU funct3; the alt flag turns add into sub and srl into sra
  typedef enum logic [2:0] {
    ALU_ADD  = 3'd0,
    ALU_SLL  = 3'd1,
    ALU_SLT  = 3'd2,
    ALU_SLTU = 3'd3,
    ALU_XOR  = 3'd4,
    ALU_SRL  = 3'd5,
    ALU_OR   = 3'd6,
    ALU_AND  = 3'd7
  } alu_fn_t;

  // M extension funct3, bit 2 picks the divider
  typedef enum logic [2:0] {
    MD_MUL    = 3'd0,
    MD_MULH   = 3'd1,
    MD_MULHSU = 3'd2,
    MD_MULHU  = 3'd3,
    MD_DIV    = 3'd4,
    MD_DIVU   = 3'd5,
    MD_REM    = 3'd6,
    MD_REMU   = 3'd7
  } md_fn_t;

  // Load/store access size, funct3 bits 1:0
  typedef enum logic [1:0] {
    LS_BYTE = 2'd0,
    LS_HALF = 2'd1,
    LS_WORD = 2'd2
  } ls_size_t;

  // Unsigned load flag sits in funct3 bit 2
  localparam int LS_UNSIGNED_BIT = 2;

endpackage

// File: exu_if.sv
`timescale 1ns/1ps

// Operands and function for the combinational ALU
interface alu_if;
  logic [bus_pkg::XLEN-1:0] a;
  logic [bus_pkg::XLEN-1:0] b;
  exu_pkg::alu_fn_t         fn;
  logic                     alt;
  logic [bus_pkg::XLEN-1:0] result;

  modport ctrl (output a, b, fn, alt, input result);
  modport unit (input a, b, fn, alt, output result);
endinterface

// Request/result link to one sequential unit
interface fu_if;
  logic                     req_valid;
  logic                     req_ready;
  logic [bus_pkg::XLEN-1:0] a;
  logic [bus_pkg::XLEN-1:0] b;
  logic [bus_pkg::XLEN-1:0] c;
  logic [2:0]               fn;
  logic                     res_valid;
  logic                     res_ready;
  logic [bus_pkg::XLEN-1:0] result;

  modport ctrl (
    output req_valid, a, b, c, fn, res_ready,
    input  req_ready, res_valid, result
  );
  modport unit (
    input  req_valid, a, b, c, fn, res_ready,
    output req_ready, res_valid, result
  );
endinterface

// File: exu_alu.sv
`timescale 1ns/1ps

module exu_alu (
  alu_if.unit alu
);

  logic [4:0]               shamt;
  logic [bus_pkg::XLEN-1:0] sum;
  logic [bus_pkg::XLEN-1:0] shr;

  assign shamt = alu.b[4:0];

  // alt turns the adder into a subtractor
  assign sum = alu.alt ? alu.a - alu.b : alu.a + alu.b;

  // Arithmetic or logical right shift
  assign shr = alu.alt ? bus_pkg::XLEN'($signed(alu.a) >>> shamt) : alu.a >> shamt;

  always_comb begin
    case (alu.fn)
      exu_pkg::ALU_ADD:  alu.result = sum;
      exu_pkg::ALU_SLL:  alu.result = alu.a << shamt;
      exu_pkg::ALU_SLT: begin
        alu.result = {{(bus_pkg::XLEN-1){1'b0}}, $signed(alu.a) < $signed(alu.b)};
      end
      exu_pkg::ALU_SLTU: begin
        alu.result = {{(bus_pkg::XLEN-1){1'b0}}, alu.a < alu.b};
      end
      exu_pkg::ALU_XOR:  alu.result = alu.a ^ alu.b;
      exu_pkg::ALU_SRL:  alu.result = shr;
      exu_pkg::ALU_OR:   alu.result = alu.a | alu.b;
      exu_pkg::ALU_AND:  alu.result = alu.a & alu.b;
      default:           alu.result = sum;
    endcase
  end

endmodule

// File: exu_mul.sv
`timescale 1ns/1ps

module exu_mul (
  input logic clock,
  input logic reset,
  input logic flush,
  fu_if.unit  fu
);

  typedef enum logic [1:0] {IDLE, BUSY, DONE} state_t;

  state_t      state;
  logic [4:0]  count;
  logic [31:0] mcand;
  logic [63:0] prod;
  logic        neg;
  logic        high;
  logic        a_signed;
  logic        b_signed;
  logic [32:0] acc;
  logic [63:0] prod_fix;

  // mulh: both signed, mulhsu: only a, mulhu and mul: neither
  assign a_signed = (fu.fn == exu_pkg::MD_MULH) || (fu.fn == exu_pkg::MD_MULHSU);
  assign b_signed = (fu.fn == exu_pkg::MD_MULH);

  // One shift-add step on the upper half
  assign acc = {1'b0, prod[63:32]} + (prod[0] ? {1'b0, mcand} : 33'd0);

  assign prod_fix  = neg ? -prod : prod;
  assign fu.result = high ? prod_fix[63:32] : prod_fix[31:0];

  assign fu.req_ready = (state == IDLE);
  assign fu.res_valid = (state == DONE);

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: if (fu.req_valid) state <= BUSY;
        BUSY: if (count == 5'd31) state <= DONE;
        DONE: if (fu.res_ready) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == IDLE && fu.req_valid) begin
      mcand <= (a_signed && fu.a[31]) ? -fu.a : fu.a;
      prod  <= {32'd0, (b_signed && fu.b[31]) ? -fu.b : fu.b};
      neg   <= (a_signed && fu.a[31]) ^ (b_signed && fu.b[31]);
      high  <= (fu.fn != exu_pkg::MD_MUL);
      count <= 5'd0;
    end else if (state == BUSY) begin
      prod  <= {acc, prod[31:1]};
      count <= count + 5'd1;
    end
  end

endmodule

// File: exu_div.sv
`timescale 1ns/1ps

module exu_div (
  input logic clock,
  input logic reset,
  input logic flush,
  fu_if.unit  fu
);

  typedef enum logic [1:0] {IDLE, BUSY, FIX, DONE} state_t;

  state_t      state;
  logic [4:0]  count;
  logic [31:0] divisor;
  logic [31:0] rem;
  logic [31:0] quo;
  logic        neg_q;
  logic        neg_r;
  logic        sel_rem;
  logic [31:0] result_q;
  logic        is_signed;
  logic        div_zero;
  logic [32:0] shifted;
  logic [33:0] diff;

  // div and rem are signed, divu and remu are not
  assign is_signed = ~fu.fn[0];
  assign div_zero  = (fu.b == 32'd0);

  // Restoring step: shift in the next dividend bit and try to subtract
  assign shifted = {rem, quo[31]};
  assign diff    = {1'b0, shifted} - {2'b00, divisor};

  assign fu.req_ready = (state == IDLE);
  assign fu.res_valid = (state == DONE);
  assign fu.result    = result_q;

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: if (fu.req_valid) state <= div_zero ? DONE : BUSY;
        BUSY: if (count == 5'd31) state <= FIX;
        FIX:  state <= DONE;
        DONE: if (fu.res_ready) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == IDLE && fu.req_valid) begin
      // Divide by zero answers at once: all ones, or the dividend for rem
      result_q <= fu.fn[1] ? fu.a : 32'hffff_ffff;
      quo      <= (is_signed && fu.a[31]) ? -fu.a : fu.a;
      divisor  <= (is_signed && fu.b[31]) ? -fu.b : fu.b;
      rem      <= 32'd0;
      neg_q    <= is_signed && (fu.a[31] ^ fu.b[31]);
      neg_r    <= is_signed && fu.a[31];
      sel_rem  <= fu.fn[1];
      count    <= 5'd0;
    end else if (state == BUSY) begin
      if (diff[33]) begin
        rem <= shifted[31:0];
        quo <= {quo[30:0], 1'b0};
      end else begin
        rem <= diff[31:0];
        quo <= {quo[30:0], 1'b1};
      end
      count <= count + 5'd1;
    end else if (state == FIX) begin
      // Most negative by minus one wraps back to itself with rem zero
      result_q <= sel_rem ? (neg_r ? -rem : rem) : (neg_q ? -quo : quo);
    end
  end

endmodule

// File: exu_lsu.sv
`timescale 1ns/1ps

module exu_lsu (
  input  logic                        clock,
  input  logic                        reset,
  fu_if.unit                          fu,
  output logic                        psel,
  output logic                        penable,
  output logic                        pwrite,
  output logic [bus_pkg::ADDR_W-1:0]  paddr,
  output logic [bus_pkg::XLEN-1:0]    pwdata,
  output logic [bus_pkg::STRB_W-1:0]  pstrb,
  input  logic [31:0]                 prdata,
  input  logic                        pready,
  input  logic                        pslverr
);

  typedef enum logic [1:0] {IDLE, SETUP, ACCESS} state_t;

  state_t                   state;
  logic                     res_valid_q;
  logic [bus_pkg::XLEN-1:0] result_q;
  exu_pkg::ls_size_t        size;
  exu_pkg::ls_size_t        size_q;
  logic                     uns_q;
  logic [1:0]               offset_q;
  logic                     is_store;
  logic [bus_pkg::XLEN-1:0] lane;
  logic [bus_pkg::XLEN-1:0] load_val;

  assign size     = exu_pkg::ls_size_t'(fu.fn[1:0]);
  assign is_store = (fu.b[1:0] == exu_pkg::UNIT_STORE);

  assign fu.req_ready = (state == IDLE) && !res_valid_q;
  assign fu.res_valid = res_valid_q;
  assign fu.result    = result_q;

  assign psel    = (state != IDLE);
  assign penable = (state == ACCESS);

  // Move the addressed lane down, then extend
  assign lane = prdata >> {offset_q, 3'b000};
  always_comb begin
    case (size_q)
      exu_pkg::LS_BYTE: load_val = {{24{~uns_q & lane[7]}}, lane[7:0]};
      exu_pkg::LS_HALF: load_val = {{16{~uns_q & lane[15]}}, lane[15:0]};
      default:          load_val = lane;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state       <= IDLE;
      res_valid_q <= 1'b0;
    end else begin
      case (state)
        IDLE:   if (fu.req_valid && fu.req_ready) state <= SETUP;
        SETUP:  state <= ACCESS;
        ACCESS: if (pready) state <= IDLE;
        default: state <= IDLE;
      endcase
      if (state == ACCESS && pready) begin
        res_valid_q <= 1'b1;
      end else if (fu.res_ready) begin
        res_valid_q <= 1'b0;
      end
    end
  end

  // Slave errors are not reported back to the core
  always_ff @(posedge clock) begin
    if (state == IDLE && fu.req_valid && fu.req_ready) begin
      paddr    <= {fu.a[bus_pkg::ADDR_W-1:2], 2'b00};
      pwrite   <= is_store;
      size_q   <= size;
      uns_q    <= fu.fn[exu_pkg::LS_UNSIGNED_BIT];
      offset_q <= fu.a[1:0];
      case (size)
        exu_pkg::LS_BYTE: begin
          pwdata <= {4{fu.c[7:0]}};
          pstrb  <= 4'b0001 << fu.a[1:0];
        end
        exu_pkg::LS_HALF: begin
          pwdata <= {2{fu.c[15:0]}};
          pstrb  <= 4'b0011 << {fu.a[1], 1'b0};
        end
        default: begin
          pwdata <= fu.c;
          pstrb  <= 4'b1111;
        end
      endcase
      // Reads carry no strobes
      if (!is_store) pstrb <= 4'b0000;
    end
    if (state == ACCESS && pready) result_q <= load_val;
  end

endmodule

// File: exu_ctrl.sv
`timescale 1ns/1ps

module exu_ctrl (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     flush,
  input  logic                     in_valid,
  input  logic [bus_pkg::XLEN-1:0] in_pc,
  input  logic [1:0]               in_unit,
  input  logic [2:0]               in_fn,
  input  logic                     in_alt,
  input  logic [bus_pkg::XLEN-1:0] in_a,
  input  logic [bus_pkg::XLEN-1:0] in_b,
  input  logic [bus_pkg::XLEN-1:0] in_c,
  input  logic [4:0]               in_rd,
  input  logic                     out_ready,
  output logic                     in_ready,
  output logic                     out_valid,
  output logic [bus_pkg::XLEN-1:0] out_pc,
  output logic [4:0]               out_rd,
  output logic [bus_pkg::XLEN-1:0] out_wdata,
  alu_if.ctrl                      alu,
  fu_if.ctrl                       mul,
  fu_if.ctrl                       div,
  fu_if.ctrl                       lsu
);

  logic                     valid_q;
  logic                     dispatched_q;
  logic                     drain_q;
  logic [bus_pkg::XLEN-1:0] pc_q;
  logic [bus_pkg::XLEN-1:0] a_q;
  logic [bus_pkg::XLEN-1:0] b_q;
  logic [bus_pkg::XLEN-1:0] c_q;
  exu_pkg::unit_t           unit_q;
  logic [2:0]               fn_q;
  logic                     alt_q;
  logic [4:0]               rd_q;
  logic sel_alu, sel_mul, sel_div, sel_lsu;
  logic unit_done, issue, leave, sent, lsu_busy, pending;

  assign sel_alu = (unit_q == exu_pkg::UNIT_ALU);
  assign sel_mul = (unit_q == exu_pkg::UNIT_MULDIV) && !fn_q[2];
  assign sel_div = (unit_q == exu_pkg::UNIT_MULDIV) && fn_q[2];
  assign sel_lsu = (unit_q == exu_pkg::UNIT_LOAD) || (unit_q == exu_pkg::UNIT_STORE);

  // Memory ops reuse the ALU adder for the address
  assign alu.a   = a_q;
  assign alu.b   = b_q;
  assign alu.fn  = sel_lsu ? exu_pkg::ALU_ADD : exu_pkg::alu_fn_t'(fn_q);
  assign alu.alt = alt_q && !sel_lsu;

  // One request per instruction, never in a flush cycle
  assign pending       = valid_q && !dispatched_q && !flush;
  assign mul.req_valid = pending && sel_mul;
  assign div.req_valid = pending && sel_div;
  assign lsu.req_valid = pending && sel_lsu;
  assign sent = (mul.req_valid && mul.req_ready) || (div.req_valid && div.req_ready) ||
                (lsu.req_valid && lsu.req_ready);

  assign mul.a = a_q;
  assign mul.b = b_q;
  assign mul.c = c_q;
  assign mul.fn = fn_q;
  assign div.a = a_q;
  assign div.b = b_q;
  assign div.c = c_q;
  assign div.fn = fn_q;
  assign lsu.a = alu.result;
  assign lsu.b = {{(bus_pkg::XLEN-2){1'b0}}, unit_q};
  assign lsu.c = c_q;
  assign lsu.fn = fn_q;

  // A drained LSU result after flush is taken here and dropped
  assign mul.res_ready = valid_q && sel_mul && out_ready && !flush;
  assign div.res_ready = valid_q && sel_div && out_ready && !flush;
  assign lsu.res_ready = drain_q || (valid_q && sel_lsu && out_ready && !flush);

  always_comb begin
    unit_done = sel_alu;
    out_wdata = alu.result;
    if (sel_mul) begin
      unit_done = mul.res_valid;
      out_wdata = mul.result;
    end else if (sel_div) begin
      unit_done = div.res_valid;
      out_wdata = div.result;
    end else if (sel_lsu) begin
      unit_done = lsu.res_valid;
      out_wdata = lsu.result;
    end
  end

  assign out_valid = valid_q && unit_done && !flush;
  assign out_pc    = pc_q;
  assign out_rd    = rd_q;
  assign leave     = out_valid && out_ready;
  assign in_ready  = (!valid_q || leave) && !drain_q && !flush;
  assign issue     = in_valid && in_ready;
  assign lsu_busy  = !lsu.req_ready && !(lsu.res_valid && lsu.res_ready);

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q      <= 1'b0;
      dispatched_q <= 1'b0;
      drain_q      <= 1'b0;
    end else begin
      if (flush) valid_q <= 1'b0;
      else if (issue) valid_q <= 1'b1;
      else if (leave) valid_q <= 1'b0;
      if (flush || issue) dispatched_q <= 1'b0;
      else if (sent) dispatched_q <= 1'b1;
      // Wait for a started APB transfer to finish
      if (flush && lsu_busy) drain_q <= 1'b1;
      else if (lsu.res_valid && lsu.res_ready) drain_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (issue) begin
      pc_q   <= in_pc;
      unit_q <= exu_pkg::unit_t'(in_unit);
      fn_q   <= in_fn;
      alt_q  <= in_alt;
      a_q    <= in_a;
      b_q    <= in_b;
      c_q    <= in_c;
      rd_q   <= in_rd;
    end
  end

endmodule

// File: exu_top.sv
`timescale 1ns/1ps

module exu_top (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        flush,
  // Issue side
  input  logic                        in_valid,
  output logic                        in_ready,
  input  logic [bus_pkg::XLEN-1:0]    in_pc,
  input  logic [1:0]                  in_unit,
  input  logic [2:0]                  in_fn,
  input  logic                        in_alt,
  input  logic [bus_pkg::XLEN-1:0]    in_a,
  input  logic [bus_pkg::XLEN-1:0]    in_b,
  input  logic [bus_pkg::XLEN-1:0]    in_c,
  input  logic [4:0]                  in_rd,
  // Writeback side
  output logic                        out_valid,
  input  logic                        out_ready,
  output logic [bus_pkg::XLEN-1:0]    out_pc,
  output logic [4:0]                  out_rd,
  output logic [bus_pkg::XLEN-1:0]    out_wdata,
  // APB master
  output logic                        psel,
  output logic                        penable,
  output logic                        pwrite,
  output logic [bus_pkg::ADDR_W-1:0]  paddr,
  output logic [bus_pkg::XLEN-1:0]    pwdata,
  output logic [bus_pkg::STRB_W-1:0]  pstrb,
  input  logic [bus_pkg::XLEN-1:0]    prdata,
  input  logic                        pready,
  input  logic                        pslverr
);

  alu_if alu_bus ();
  fu_if  mul_bus ();
  fu_if  div_bus ();
  fu_if  lsu_bus ();

  exu_ctrl ctrl_i (
    .clock(clock), .reset(reset), .flush(flush),
    .in_valid(in_valid), .in_pc(in_pc), .in_unit(in_unit), .in_fn(in_fn),
    .in_alt(in_alt), .in_a(in_a), .in_b(in_b), .in_c(in_c), .in_rd(in_rd),
    .out_ready(out_ready), .in_ready(in_ready), .out_valid(out_valid),
    .out_pc(out_pc), .out_rd(out_rd), .out_wdata(out_wdata),
    .alu(alu_bus.ctrl), .mul(mul_bus.ctrl), .div(div_bus.ctrl), .lsu(lsu_bus.ctrl)
  );

  exu_alu alu_i (.alu(alu_bus.unit));

  exu_mul mul_i (.clock(clock), .reset(reset), .flush(flush), .fu(mul_bus.unit));

  exu_div div_i (.clock(clock), .reset(reset), .flush(flush), .fu(div_bus.unit));

  exu_lsu lsu_i (
    .clock(clock), .reset(reset), .fu(lsu_bus.unit),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
    .pwdata(pwdata), .pstrb(pstrb), .prdata(prdata), .pready(pready),
    .pslverr(pslverr)
  );

endmodule

// File: exu_checker.sv
`timescale 1ns/1ps

module exu_checker (
  input logic                       clock,
  input logic                       reset,
  input logic                       flush,
  input logic                       out_valid,
  input logic                       out_ready,
  input logic [bus_pkg::XLEN-1:0]   out_wdata,
  input logic                       psel,
  input logic                       penable,
  input logic                       pwrite,
  input logic [bus_pkg::ADDR_W-1:0] paddr,
  input logic [bus_pkg::XLEN-1:0]   pwdata
);

  // A waiting writeback holds until taken, unless flushed
  wb_hold: assert property (@(posedge clock) disable iff (reset || flush)
    out_valid && !out_ready |=> out_valid && $stable(out_wdata))
    else $error("writeback dropped or changed before out_ready");

  // Access phase follows a setup phase
  apb_setup_first: assert property (@(posedge clock) disable iff (reset)
    $rose(penable) |-> psel && $past(psel))
    else $error("penable rose without a setup cycle");

  apb_stable: assert property (@(posedge clock) disable iff (reset)
    psel && penable |-> $stable(paddr) && $stable(pwrite) && $stable(pwdata))
    else $error("APB address or data changed during access");

  // First cycle out of reset
  reset_quiet: assert property (@(posedge clock)
    $fell(reset) |-> !out_valid && !psel)
    else $error("out_valid or psel high right after reset");

endmodule

bind exu_top exu_checker checker_i (
  .clock(clock), .reset(reset), .flush(flush),
  .out_valid(out_valid), .out_ready(out_ready), .out_wdata(out_wdata),
  .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata)
);

// File: exu_tb.sv
`timescale 1ns/1ps

module exu_tb;

  localparam int WAIT_LIMIT = 4 * bus_pkg::APB_TIMEOUT;

  typedef struct packed {
    logic [1:0]  unit;
    logic [2:0]  fn;
    logic        alt;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [4:0]  rd;
    logic [31:0] exp;
    logic        chk;
    logic        fl;
  } entry_t;

  logic        clock;
  logic        reset;
  logic        flush;
  logic        in_valid;
  logic        in_ready;
  logic [31:0] in_pc;
  logic [1:0]  in_unit;
  logic [2:0]  in_fn;
  logic        in_alt;
  logic [31:0] in_a;
  logic [31:0] in_b;
  logic [31:0] in_c;
  logic [4:0]  in_rd;
  logic        out_valid;
  logic        out_ready = 1'b0;
  logic [31:0] out_pc;
  logic [4:0]  out_rd;
  logic [31:0] out_wdata;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] paddr;
  logic [31:0] pwdata;
  logic [3:0]  pstrb;
  logic [31:0] prdata = 32'd0;
  logic        pready = 1'b0;
  logic        pslverr = 1'b0;

  logic [31:0] mem [0:255];
  integer      seed = 32'h080e8599;
  int          wait_left;
  int          wb_count = 0;
  entry_t      entries [$];

  exu_top dut_i (.*);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // APB slave, 0 to 3 wait states, word pattern reloaded during reset
  always @(posedge clock) begin
    int draw;
    if (reset) begin
      for (int i = 0; i < 256; i++) begin
        mem[i] <= {8'(i), ~8'(i), 8'(i) + 8'h11, 8'(i) ^ 8'h5a};
      end
      pready    <= 1'b0;
      out_ready <= 1'b0;
    end else begin
      out_ready <= ($random(seed) & 3) != 0;
      if (psel && !penable) begin
        draw = $random(seed) & 3;
        wait_left <= draw;
        pready    <= (draw == 0);
        prdata    <= mem[paddr[9:2]];
      end else if (psel && penable && !pready) begin
        wait_left <= wait_left - 1;
        pready    <= (wait_left == 1);
      end else if (psel && penable) begin
        for (int l = 0; l < 4; l++) begin
          if (pwrite && pstrb[l]) mem[paddr[9:2]][8*l +: 8] <= pwdata[8*l +: 8];
        end
        pready <= 1'b0;
      end
    end
  end

  // Every writeback handshake
  always @(negedge clock) begin
    if (!reset && out_valid && out_ready) wb_count <= wb_count + 1;
  end

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic push_entry(input logic [1:0] unit, input logic [2:0] fn, input logic alt,
                            input logic [31:0] a, input logic [31:0] b, input logic [31:0] c,
                            input logic [31:0] exp, input logic chk, input logic fl);
    entry_t e;
    e.unit = unit;
    e.fn   = fn;
    e.alt  = alt;
    e.a    = a;
    e.b    = b;
    e.c    = c;
    e.rd   = (unit == exu_pkg::UNIT_STORE) ? 5'd0 : 5'(entries.size() % 31 + 1);
    e.exp  = exp;
    e.chk  = chk;
    e.fl   = fl;
    entries.push_back(e);
  endtask

  task automatic alu_entry(input logic [2:0] fn, input logic alt, input logic [31:0] a,
                           input logic [31:0] b, input logic [31:0] exp);
    push_entry(exu_pkg::UNIT_ALU, fn, alt, a, b, 32'd0, exp, 1'b1, 1'b0);
  endtask

  task automatic md_entry(input logic [2:0] fn, input logic [31:0] a, input logic [31:0] b,
                          input logic [31:0] exp);
    push_entry(exu_pkg::UNIT_MULDIV, fn, 1'b0, a, b, 32'd0, exp, 1'b1, 1'b0);
  endtask

  task automatic store_entry(input logic [1:0] size, input logic [31:0] a,
                             input logic [31:0] b, input logic [31:0] data);
    push_entry(exu_pkg::UNIT_STORE, {1'b0, size}, 1'b0, a, b, data, 32'd0, 1'b0, 1'b0);
  endtask

  task automatic load_entry(input logic uns, input logic [1:0] size, input logic [31:0] a,
                            input logic [31:0] b, input logic [31:0] exp);
    push_entry(exu_pkg::UNIT_LOAD, {uns, size}, 1'b0, a, b, 32'd0, exp, 1'b1, 1'b0);
  endtask

  task automatic flush_entry(input logic [1:0] unit, input logic [2:0] fn,
                             input logic [31:0] a, input logic [31:0] b);
    push_entry(unit, fn, 1'b0, a, b, 32'd0, 32'd0, 1'b0, 1'b1);
  endtask

  task automatic build_table();
    alu_entry(exu_pkg::ALU_ADD,  1'b0, 32'h7fff_ffff, 32'h0000_0001, 32'h8000_0000);
    alu_entry(exu_pkg::ALU_ADD,  1'b1, 32'h0000_0000, 32'h0000_0001, 32'hffff_ffff);
    alu_entry(exu_pkg::ALU_SLL,  1'b0, 32'h0000_0001, 32'h0000_003f, 32'h8000_0000);
    alu_entry(exu_pkg::ALU_SLT,  1'b0, 32'h8000_0000, 32'h0000_0001, 32'h0000_0001);
    alu_entry(exu_pkg::ALU_SLT,  1'b0, 32'h0000_0001, 32'hffff_ffff, 32'h0000_0000);
    alu_entry(exu_pkg::ALU_SLTU, 1'b0, 32'h0000_0001, 32'hffff_ffff, 32'h0000_0001);
    alu_entry(exu_pkg::ALU_SLTU, 1'b0, 32'h8000_0000, 32'h0000_0001, 32'h0000_0000);
    alu_entry(exu_pkg::ALU_XOR,  1'b0, 32'hff00_ff00, 32'h0ff0_0ff0, 32'hf0f0_f0f0);
    alu_entry(exu_pkg::ALU_SRL,  1'b0, 32'h8000_0000, 32'h0000_0004, 32'h0800_0000);
    alu_entry(exu_pkg::ALU_SRL,  1'b1, 32'h8000_0000, 32'h0000_0004, 32'hf800_0000);
    alu_entry(exu_pkg::ALU_OR,   1'b0, 32'h1234_0000, 32'h0000_5678, 32'h1234_5678);
    alu_entry(exu_pkg::ALU_AND,  1'b0, 32'hf0f0_f0f0, 32'hff00_ff00, 32'hf000_f000);
    md_entry(exu_pkg::MD_MUL,    32'h0000_0007, 32'hffff_fffd, 32'hffff_ffeb);
    md_entry(exu_pkg::MD_MULH,   32'hffff_ffff, 32'hffff_ffff, 32'h0000_0000);
    md_entry(exu_pkg::MD_MULHU,  32'hffff_ffff, 32'hffff_ffff, 32'hffff_fffe);
    md_entry(exu_pkg::MD_MULHSU, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff);
    md_entry(exu_pkg::MD_MULH,   32'h8000_0000, 32'h7fff_ffff, 32'hc000_0000);
    md_entry(exu_pkg::MD_MULHSU, 32'h8000_0000, 32'hffff_ffff, 32'h8000_0000);
    // Divide aborted by flush, then the divider must still work
    flush_entry(exu_pkg::UNIT_MULDIV, exu_pkg::MD_DIV, 32'd100, 32'd7);
    md_entry(exu_pkg::MD_DIV,  32'd20,          32'hffff_fffd, 32'hffff_fffa);
    md_entry(exu_pkg::MD_REM,  32'd20,          32'hffff_fffd, 32'h0000_0002);
    md_entry(exu_pkg::MD_DIV,  32'hffff_ffec,   32'd3,         32'hffff_fffa);
    md_entry(exu_pkg::MD_REM,  32'hffff_ffec,   32'd3,         32'hffff_fffe);
    md_entry(exu_pkg::MD_DIVU, 32'hffff_ffff,   32'd2,         32'h7fff_ffff);
    md_entry(exu_pkg::MD_REMU, 32'hffff_ffff,   32'd2,         32'h0000_0001);
    md_entry(exu_pkg::MD_DIV,  32'd5,           32'd0,         32'hffff_ffff);
    md_entry(exu_pkg::MD_REM,  32'hffff_fffb,   32'd0,         32'hffff_fffb);
    md_entry(exu_pkg::MD_REMU, 32'd7,           32'd0,         32'h0000_0007);
    md_entry(exu_pkg::MD_DIV,  32'h8000_0000,   32'hffff_ffff, 32'h8000_0000);
    md_entry(exu_pkg::MD_REM,  32'h8000_0000,   32'hffff_ffff, 32'h0000_0000);
    store_entry(exu_pkg::LS_WORD, 32'h40, 32'd0, 32'h1122_3344);
    store_entry(exu_pkg::LS_BYTE, 32'h40, 32'd1, 32'haaaa_aa80);
    store_entry(exu_pkg::LS_HALF, 32'h40, 32'd2, 32'h5555_beef);
    store_entry(exu_pkg::LS_BYTE, 32'h44, 32'd0, 32'h0000_0081);
    store_entry(exu_pkg::LS_BYTE, 32'h44, 32'd1, 32'h0000_0002);
    store_entry(exu_pkg::LS_BYTE, 32'h44, 32'd2, 32'h0000_00f3);
    store_entry(exu_pkg::LS_BYTE, 32'h44, 32'd3, 32'h0000_007c);
    store_entry(exu_pkg::LS_HALF, 32'h48, 32'd0, 32'h1234_9abc);
    load_entry(1'b0, exu_pkg::LS_WORD, 32'h40, 32'd0, 32'hbeef_8044);
    load_entry(1'b0, exu_pkg::LS_BYTE, 32'h40, 32'd1, 32'hffff_ff80);
    load_entry(1'b1, exu_pkg::LS_BYTE, 32'h40, 32'd1, 32'h0000_0080);
    load_entry(1'b0, exu_pkg::LS_HALF, 32'h40, 32'd2, 32'hffff_beef);
    load_entry(1'b1, exu_pkg::LS_HALF, 32'h40, 32'd2, 32'h0000_beef);
    load_entry(1'b0, exu_pkg::LS_BYTE, 32'h44, 32'd0, 32'hffff_ff81);
    load_entry(1'b1, exu_pkg::LS_BYTE, 32'h44, 32'd1, 32'h0000_0002);
    load_entry(1'b0, exu_pkg::LS_BYTE, 32'h44, 32'd2, 32'hffff_fff3);
    load_entry(1'b1, exu_pkg::LS_BYTE, 32'h44, 32'd3, 32'h0000_007c);
    load_entry(1'b0, exu_pkg::LS_HALF, 32'h44, 32'd2, 32'h0000_7cf3);
    // Load aborted mid transfer
    flush_entry(exu_pkg::UNIT_LOAD, {1'b0, exu_pkg::LS_WORD}, 32'h40, 32'd0);
    load_entry(1'b0, exu_pkg::LS_WORD, 32'h44, 32'd0, 32'h7cf3_0281);
    load_entry(1'b0, exu_pkg::LS_WORD, 32'h48, 32'd0, 32'h12ed_9abc);
    load_entry(1'b0, exu_pkg::LS_HALF, 32'h48, 32'd2, 32'h0000_12ed);
    load_entry(1'b1, exu_pkg::LS_HALF, 32'h50, 32'hffff_fff8, 32'h0000_9abc);
    load_entry(1'b0, exu_pkg::LS_WORD, 32'h80, 32'd0, 32'h20df_317a);
  endtask

  task automatic issue(input entry_t e, input logic [31:0] pc, input int idx);
    int t;
    t = 0;
    @(posedge clock);
    in_valid <= 1'b1;
    in_pc    <= pc;
    in_unit  <= e.unit;
    in_fn    <= e.fn;
    in_alt   <= e.alt;
    in_a     <= e.a;
    in_b     <= e.b;
    in_c     <= e.c;
    in_rd    <= e.rd;
    @(negedge clock);
    while (!in_ready && t < WAIT_LIMIT) begin
      @(negedge clock);
      t++;
    end
    if (!in_ready) stop_run($sformatf("timeout: entry %0d was never accepted", idx));
    @(posedge clock);
    in_valid <= 1'b0;
  endtask

  task automatic wait_writeback(input int idx);
    int t;
    t = 0;
    @(negedge clock);
    while (!(out_valid && out_ready) && t < WAIT_LIMIT) begin
      @(negedge clock);
      t++;
    end
    if (!(out_valid && out_ready)) begin
      stop_run($sformatf("timeout: entry %0d produced no writeback", idx));
    end
  endtask

  // Flush two cycles after acceptance, then watch for a stray writeback
  task automatic apply_flush();
    for (int k = 0; k < 8; k++) begin
      @(posedge clock);
      flush <= (k == 1);
      @(negedge clock);
      check_value("out_valid around flush", {31'd0, out_valid}, 32'd0);
    end
  endtask

  initial begin
    entry_t      e;
    logic [31:0] pc;
    int          expected_wb;
    expected_wb = 0;
    reset    = 1'b1;
    flush    = 1'b0;
    in_valid = 1'b0;
    in_pc    = 32'd0;
    in_unit  = 2'd0;
    in_fn    = 3'd0;
    in_alt   = 1'b0;
    in_a     = 32'd0;
    in_b     = 32'd0;
    in_c     = 32'd0;
    in_rd    = 5'd0;
    build_table();
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    check_value("in_ready after reset", {31'd0, in_ready}, 32'd1);
    check_value("out_valid after reset", {31'd0, out_valid}, 32'd0);
    check_value("psel after reset", {31'd0, psel}, 32'd0);
    for (int i = 0; i < entries.size(); i++) begin
      e  = entries[i];
      pc = 32'h1000 + 32'(4 * i);
      issue(e, pc, i);
      if (e.fl) begin
        apply_flush();
      end else begin
        wait_writeback(i);
        check_value($sformatf("entry %0d pc", i), out_pc, pc);
        check_value($sformatf("entry %0d rd", i), {27'd0, out_rd}, {27'd0, e.rd});
        if (e.chk) check_value($sformatf("entry %0d wdata", i), out_wdata, e.exp);
        expected_wb++;
      end
    end
    repeat (10) @(posedge clock);
    check_value("writeback count", 32'(wb_count), 32'(expected_wb));
    $display("Regression passed");
    $finish;
  end

endmodule

// File: flist.f
bus_pkg.sv
exu_pkg.sv
exu_if.sv
exu_alu.sv
exu_mul.sv
exu_div.sv
exu_lsu.sv
exu_ctrl.sv
exu_top.sv
exu_checker.sv
exu_tb.sv

// File: Makefile
SIM := obj_dir/Vexu_tb

.PHONY: run clean

run: $(SIM)
	./$(SIM)

$(SIM): flist.f $(wildcard *.sv)
	verilator --binary --timing --assert --top-module exu_tb -f flist.f

clean:
	rm -rf obj_dir
